// File: project.f
verilog/saturn_pkg.sv
verilog/saturn_ifs.sv
verilog/saturn_inst_decoder.sv
verilog/saturn_regs_pc_rstk.sv
verilog/saturn_bus_ctrl.sv
verilog/saturn_control_unit.sv
verilog/saturn_core.sv
verification/saturn_core_tb.sv

// File: Makefile
# Verilator build and run of the nibble-serial core testbench.

all: run

run:
	verilator --binary --timing --top-module saturn_core_tb -f project.f \
		--Mdir obj_dir -o saturn_core_tb
	./obj_dir/saturn_core_tb | tee sim.log
	grep -q "TEST OK" sim.log

lint:
	verilator --lint-only --timing --top-module saturn_core -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: verification/saturn_core_tb.sv
// Testbench for the processor front end.
// A nibble memory model answers the four-phase bus, directed tests load
// small programs and compare the core's ports with an instruction model.

`timescale 1ns/10ps

module saturn_core_tb import saturn_pkg::*; ();

    localparam int MEM_NIBBLES     = 256;
    localparam int FETCHED_NIBBLES = 97;        // instruction nibbles read over all tests.
    localparam int NS_PER_NIBBLE   = 200;

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        o_bus_req;
    logic        o_bus_is_cmd;
    nibble_t     o_bus_data;
    logic        i_bus_ack;
    nibble_t     i_bus_nibble;
    addr_t       o_current_pc;
    nibble_t     o_reg_p;
    instr_type_t o_instr_type;
    logic        o_instr_done;
    logic        o_error;

    nibble_t     mem [MEM_NIBBLES];
    addr_t       mem_ptr;                       // memory's own read pointer.
    int          addr_idx;                      // next LOAD_PC address nibble.
    int          ack_wait;                      // cycles before the next ack.
    bit          random_delay;
    logic [31:0] lcg_state = 32'hcfaa_34f2;
    logic [4:0]  xfer_log [$];                  // {is_cmd, data} per transfer.
    addr_t       load_log [$];                  // addresses sent by LOAD_PC.

    addr_t       exp_pc;                        // instruction model state.
    nibble_t     exp_p;
    instr_type_t exp_type;
    logic        exp_err;
    addr_t       ret_stack [$];                 // front is the newest entry.
    addr_t       exp_loads [$];
    int          checks = 0;
    int          errors = 0;

    saturn_core UUT (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .o_bus_req    (o_bus_req),
        .o_bus_is_cmd (o_bus_is_cmd),
        .o_bus_data   (o_bus_data),
        .i_bus_ack    (i_bus_ack),
        .i_bus_nibble (i_bus_nibble),
        .o_current_pc (o_current_pc),
        .o_reg_p      (o_reg_p),
        .o_instr_type (o_instr_type),
        .o_instr_done (o_instr_done),
        .o_error      (o_error)
    );

    always #5 i_clk = ~i_clk;                   // 10 ns period.

    initial begin
        #(FETCHED_NIBBLES * NS_PER_NIBBLE);
        $display("Watchdog expired at %0t, the tests did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic nibble_t mem_at(input addr_t a);
        return mem[a[7:0]];                     // address wraps at 256 nibbles.
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic put_nibbles(input int addr, input string hex);
        byte c;
        for (int i = 0; i < hex.len(); i++) begin
            c = hex[i];
            mem[8'(addr + i)] = (c >= "A") ? nibble_t'(c - "A" + 10) : nibble_t'(c - "0");
        end
    endtask

    // ########################################
    // memory model on the four-phase bus
    // ########################################

    task automatic serve_transfer();
        xfer_log.push_back({o_bus_is_cmd, o_bus_data});
        if (o_bus_is_cmd) begin
            addr_idx = (o_bus_data == BUSCMD_LOAD_PC) ? 0 : ADDR_NIBBLES;
            if (o_bus_data == BUSCMD_READ) begin
                i_bus_nibble = mem_at(mem_ptr);
                mem_ptr      = mem_ptr + 20'd1;  // pointer moves after each read.
            end
        end else if (addr_idx < ADDR_NIBBLES) begin
            mem_ptr[addr_idx*4 +: 4] = o_bus_data;  // lowest nibble first.
            addr_idx++;
            if (addr_idx == ADDR_NIBBLES) begin
                load_log.push_back(mem_ptr);
            end
        end
    endtask

    always begin
        @(posedge i_clk);
        #1;
        if (!i_bus_ack && o_bus_req) begin
            if (ack_wait != 0) begin
                ack_wait = ack_wait - 1;        // slow memory.
            end else begin
                serve_transfer();
                i_bus_ack = 1'b1;
            end
        end else if (i_bus_ack && !o_bus_req) begin
            i_bus_ack = 1'b0;
            ack_wait  = random_delay ? int'((lcg_next() >> 16) % 32'd4) : 0;
        end
    end

    // ########################################
    // reset and instruction model
    // ########################################

    task automatic begin_reset();
        @(posedge i_clk);
        #1;
        i_reset = 1'b1;
        for (int a = 0; a < MEM_NIBBLES; a++) begin
            mem[a] = nibble_t'(a ^ (a >> 4));   // background fill.
        end
        exp_pc  = '0;
        exp_p   = 4'h0;
        exp_err = 1'b0;
        ret_stack.delete();
        exp_loads.delete();
        exp_loads.push_back('0);                // first load after reset.
    endtask

    task automatic end_reset();
        repeat (5) @(posedge i_clk);
        #1;
        xfer_log.delete();
        load_log.delete();
        check("o_bus_req", 32'(o_bus_req), 32'h0);
        check("o_instr_done", 32'(o_instr_done), 32'h0);
        check("o_error", 32'(o_error), 32'h0);
        check("o_current_pc", 32'(o_current_pc), 32'h0);
        check("o_reg_p", 32'(o_reg_p), 32'h0);
        i_reset = 1'b0;
    endtask

    task automatic model_step();
        nibble_t op;
        offset_t off;
        op  = mem_at(exp_pc);
        off = {mem_at(exp_pc + 20'd3), mem_at(exp_pc + 20'd2), mem_at(exp_pc + 20'd1)};
        if (op == 4'h2) begin
            exp_type = INSTR_P_EQ_N;
            exp_p    = mem_at(exp_pc + 20'd1);
            exp_pc   = exp_pc + 20'd2;
        end else if (op == 4'h6) begin
            exp_type = INSTR_GOTO;
            exp_pc   = exp_pc + 20'd1 + {{8{off[11]}}, off};
            exp_loads.push_back(exp_pc);
        end else if (op == 4'h7) begin
            exp_type = INSTR_GOSUB;
            ret_stack.push_front(exp_pc + 20'd4);    // address after the GOSUB.
            if (ret_stack.size() > RSTK_DEPTH) begin
                ret_stack.delete(RSTK_DEPTH);       // oldest entry is lost.
            end
            exp_pc = exp_pc + 20'd4 + {{8{off[11]}}, off};
            exp_loads.push_back(exp_pc);
        end else if (op == 4'h0 && mem_at(exp_pc + 20'd1) == 4'h1) begin
            exp_type = INSTR_RTN;
            if (ret_stack.size() == 0) begin
                exp_pc = '0;
            end else begin
                exp_pc = ret_stack.pop_front();
            end
            exp_loads.push_back(exp_pc);
        end else begin
            exp_type = INSTR_BAD;
            if (op == 4'h0) begin
                exp_pc = exp_pc + 20'd2;        // a 0 opcode always reads a second nibble.
            end else begin
                exp_pc = exp_pc + 20'd1;        // only the opcode was read.
            end
            exp_err  = 1'b1;
        end
    endtask

    task automatic wait_instr(output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 300) begin
            @(posedge i_clk);
            #2;
            seen = o_instr_done;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout at %0t: no o_instr_done within %0d cycles", $time, cycles);
            errors++;
        end
    endtask

    task automatic run_program(input int count);
        bit seen;
        int cycles;
        for (int i = 0; i < count; i++) begin
            wait_instr(seen);
            if (!seen) begin
                return;
            end
            model_step();
            check("o_instr_type", 32'(o_instr_type), 32'(exp_type));
            check("o_current_pc", 32'(o_current_pc), 32'(exp_pc));
            check("o_reg_p", 32'(o_reg_p), 32'(exp_p));
            check("o_error", 32'(o_error), 32'(exp_err));
        end
        cycles = 0;
        while (load_log.size() < exp_loads.size() && cycles < 100) begin
            @(posedge i_clk);
            #2;
            cycles++;
        end
        if (load_log.size() < exp_loads.size()) begin
            $display("Failure at %0t: only %0d of %0d LOAD_PC transfers seen",
                     $time, load_log.size(), exp_loads.size());
            errors++;
        end else begin
            foreach (exp_loads[i]) begin
                check($sformatf("LOAD_PC address %0d", i), 32'(load_log[i]), 32'(exp_loads[i]));
            end
        end
    endtask

    // ########################################
    // directed tests
    // ########################################

    task automatic after_reset();
        int cycles;
        begin_reset();
        put_nibbles(0, "6FFF");                 // park the core in a self loop.
        end_reset();
        cycles = 0;
        while (xfer_log.size() < 6 && cycles < 100) begin
            @(posedge i_clk);
            #2;
            cycles++;
        end
        if (xfer_log.size() < 6) begin
            $display("Failure at %0t: the LOAD_PC sequence did not appear on the bus", $time);
            errors++;
        end else begin
            check("first bus transfer", 32'(xfer_log[0]), 32'({1'b1, BUSCMD_LOAD_PC}));
            for (int i = 1; i <= ADDR_NIBBLES; i++) begin
                check($sformatf("address transfer %0d", i), 32'(xfer_log[i]), 32'h0);
            end
        end
        check("o_error", 32'(o_error), 32'h0);
    endtask

    task automatic p_assignments();
        begin_reset();
        put_nibbles(0, "252A6FFF");             // P= 5, P= A, then loop.
        end_reset();
        run_program(2);
    endtask

    task automatic relative_jumps();
        begin_reset();
        put_nibbles(0, "6010");                 // forward to 0x11.
        put_nibbles(17, "2560FF");              // P= 5, back to 0x04.
        put_nibbles(4, "276FFF");
        end_reset();
        run_program(4);
    endtask

    task automatic subroutine_calls();
        begin_reset();
        put_nibbles(0, "7C106FFF");             // call 0x20, then loop at 4.
        put_nibbles(32, "2301");
        end_reset();
        run_program(3);
        begin_reset();
        for (int k = 0; k < 9; k++) begin
            put_nibbles(k * 16, "7C00");        // each block calls the next one.
            put_nibbles(k * 16 + 4, "01");
        end
        put_nibbles(144, "01");
        end_reset();
        run_program(18);                        // nine calls, nine returns.
    endtask

    task automatic bad_opcode();
        int count;
        begin_reset();
        put_nibbles(0, "253");
        end_reset();
        run_program(2);
        count = xfer_log.size();
        repeat (30) begin
            @(posedge i_clk);
            #2;
            check("o_bus_req", 32'(o_bus_req), 32'h0);
        end
        check("bus transfers after halt", 32'(xfer_log.size()), 32'(count));
        check("o_error", 32'(o_error), 32'h1);
        begin_reset();
        end_reset();                            // error must clear here.
    endtask

    initial begin
        i_reset      = 1'b1;
        i_bus_ack    = 1'b0;
        i_bus_nibble = 4'h0;
        random_delay = 1'b0;
        ack_wait     = 0;
        addr_idx     = ADDR_NIBBLES;
        mem_ptr      = '0;
        after_reset();
        p_assignments();
        relative_jumps();
        subroutine_calls();
        bad_opcode();
        random_delay = 1'b1;                    // same programs, slow memory.
        p_assignments();
        relative_jumps();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/saturn_core.sv
// Top level of the processor front end.
// Wires the control unit, decoder, pc module and bus controller together
// and exposes the four-phase nibble bus and the visible state as ports.

`timescale 1ns/10ps

module saturn_core import saturn_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    output logic        o_bus_req,
    output logic        o_bus_is_cmd,
    output nibble_t     o_bus_data,
    input  logic        i_bus_ack,
    input  nibble_t     i_bus_nibble,
    output addr_t       o_current_pc,
    output nibble_t     o_reg_p,
    output instr_type_t o_instr_type,
    output logic        o_instr_done,
    output logic        o_error
);

    logic exec;
    logic flush;

    saturn_fetch_if fetch_if ();
    saturn_dec_if   dec_if ();

    // ########################################
    // submodules
    // ########################################

    saturn_control_unit control_unit (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .io_fetch       (fetch_if.ctrl),
        .i_dec          (dec_if.ctrl),
        .i_current_pc   (o_current_pc),
        .o_exec         (exec),
        .o_flush        (flush),
        .o_instr_done   (o_instr_done),
        .o_error        (o_error),
        .o_reg_p        (o_reg_p),
        .o_instr_type   (o_instr_type)
    );

    // done also ends loads, only fetch cycles carry a nibble.
    saturn_inst_decoder inst_decoder (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_nibble_valid (fetch_if.done && fetch_if.fetch_req),
        .i_nibble       (fetch_if.nibble),
        .i_nibble_pc    (o_current_pc),
        .i_flush        (flush),
        .o_dec          (dec_if.dec)
    );

    saturn_regs_pc_rstk regs_pc_rstk (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_fetch_done   (fetch_if.done && fetch_if.fetch_req),
        .i_exec         (exec),
        .i_dec          (dec_if.pc),
        .o_current_pc   (o_current_pc)
    );

    saturn_bus_ctrl bus_ctrl (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .io_fetch       (fetch_if.bus),
        .o_bus_req      (o_bus_req),
        .o_bus_is_cmd   (o_bus_is_cmd),
        .o_bus_data     (o_bus_data),
        .i_bus_ack      (i_bus_ack),
        .i_bus_nibble   (i_bus_nibble)
    );

endmodule

// File: verilog/saturn_control_unit.sv
// Control unit.
// Loads the pc into the memory, runs the fetch loop, executes decoded
// instructions and owns the P register and the sticky error flag.

`timescale 1ns/10ps

module saturn_control_unit import saturn_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    saturn_fetch_if.ctrl io_fetch,
    saturn_dec_if.ctrl  i_dec,
    input  addr_t       i_current_pc,
    output logic        o_exec,                 // strobe to the pc module.
    output logic        o_flush,                // clears the decoder after a jump.
    output logic        o_instr_done,
    output logic        o_error,
    output nibble_t     o_reg_p,
    output instr_type_t o_instr_type
);

    ctrl_state_t state;
    logic        is_jump;

    assign is_jump = i_dec.instr_type inside {INSTR_GOTO, INSTR_GOSUB, INSTR_RTN};

    // requests follow the state, so they drop right after done.
    assign io_fetch.load_req  = (state == ST_LOAD);
    assign io_fetch.load_addr = i_current_pc;
    assign io_fetch.fetch_req = (state == ST_WAIT);

    assign o_exec  = (state == ST_EXEC) && (i_dec.instr_type != INSTR_BAD);
    assign o_flush = (state == ST_EXEC) && is_jump;

    // ########################################
    // state machine
    // ########################################

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= ST_RESET;
            o_reg_p      <= 4'h0;
            o_error      <= 1'b0;
            o_instr_done <= 1'b0;
        end else begin
            o_instr_done <= 1'b0;
            case (state)
                ST_RESET: state <= ST_LOAD;
                ST_LOAD: if (io_fetch.done) begin
                    state <= ST_FETCH;
                end
                ST_FETCH: begin
                    // the decoder answers one cycle after the last nibble.
                    state <= i_dec.instr_done ? ST_EXEC : ST_WAIT;
                end
                ST_WAIT: if (io_fetch.done) begin
                    state <= ST_FETCH;
                end
                ST_EXEC: begin
                    o_instr_done <= 1'b1;
                    case (i_dec.instr_type)
                        INSTR_P_EQ_N: begin
                            o_reg_p <= i_dec.imm;
                            state   <= ST_FETCH;
                        end
                        INSTR_BAD: begin
                            o_error <= 1'b1;    // held until reset.
                            state   <= ST_HALT;
                        end
                        default: state <= ST_LOAD;  // jumps reload the memory pointer.
                    endcase
                end
                ST_HALT: state <= ST_HALT;
                default: state <= ST_RESET;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_EXEC) begin
            o_instr_type <= i_dec.instr_type;
        end
    end

endmodule

// File: verilog/saturn_bus_ctrl.sv
// Four-phase req/ack master for the external nibble bus.
// A load request becomes LOAD_PC plus five address nibbles, lowest first;
// a fetch request becomes one READ. done pulses after the last ack falls.

`timescale 1ns/10ps

module saturn_bus_ctrl import saturn_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    saturn_fetch_if.bus io_fetch,
    output logic    o_bus_req,
    output logic    o_bus_is_cmd,
    output nibble_t o_bus_data,
    input  logic    i_bus_ack,
    input  nibble_t i_bus_nibble
);

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQ,                                // req high, waiting for ack.
        BUS_ACK                                 // req low, waiting for ack to drop.
    } bus_state_t;

    bus_state_t state;
    logic       is_load;
    logic [2:0] xfer_idx;                       // 0 is the command transfer.
    addr_t      addr_sr;                        // address nibbles still to send.
    logic       start;
    logic       last;

    // the request is still high in the done cycle, so skip it then.
    assign start = (state == BUS_IDLE) && !io_fetch.done && !i_bus_ack &&
                   (io_fetch.load_req || io_fetch.fetch_req);
    assign last  = !is_load || (xfer_idx == 3'(ADDR_NIBBLES));

    assign o_bus_is_cmd = (xfer_idx == 3'd0);
    assign o_bus_data   = (xfer_idx != 3'd0) ? addr_sr[3:0] :
                          (is_load ? BUSCMD_LOAD_PC : BUSCMD_READ);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= BUS_IDLE;
            o_bus_req     <= 1'b0;
            io_fetch.done <= 1'b0;
            is_load       <= 1'b0;
            xfer_idx      <= 3'd0;
        end else begin
            io_fetch.done <= 1'b0;
            case (state)
                BUS_IDLE: if (start) begin
                    is_load   <= io_fetch.load_req;
                    xfer_idx  <= 3'd0;
                    o_bus_req <= 1'b1;
                    state     <= BUS_REQ;
                end
                BUS_REQ: if (i_bus_ack) begin
                    o_bus_req <= 1'b0;          // nibble is taken in this cycle.
                    state     <= BUS_ACK;
                end
                BUS_ACK: if (!i_bus_ack) begin
                    if (last) begin
                        io_fetch.done <= 1'b1;
                        state         <= BUS_IDLE;
                    end else begin
                        xfer_idx  <= xfer_idx + 3'd1;
                        o_bus_req <= 1'b1;
                        state     <= BUS_REQ;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            addr_sr <= io_fetch.load_addr;
        end else if ((state == BUS_ACK) && !i_bus_ack && (xfer_idx != 3'd0)) begin
            addr_sr <= addr_sr >> 4;            // next address nibble.
        end
        if ((state == BUS_REQ) && i_bus_ack) begin
            io_fetch.nibble <= i_bus_nibble;
        end
    end

endmodule

// File: verilog/saturn_regs_pc_rstk.sv
// Program counter and return stack.
// The pc steps on every fetched nibble and is rewritten by jumps on the
// execute strobe. The stack keeps the newest RSTK_DEPTH return addresses.

`timescale 1ns/10ps

module saturn_regs_pc_rstk import saturn_pkg::*; (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_fetch_done,                 // one nibble was read.
    input  logic  i_exec,                       // execute strobe from control.
    saturn_dec_if.pc i_dec,
    output addr_t o_current_pc
);

    addr_t      pc;
    addr_t      rstk [RSTK_DEPTH];              // entry 0 is the top.
    logic [3:0] depth;                          // valid entries, saturates.
    logic       push;
    logic       pop;

    assign push         = i_exec && (i_dec.instr_type == INSTR_GOSUB);
    assign pop          = i_exec && (i_dec.instr_type == INSTR_RTN);
    assign o_current_pc = pc;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc    <= '0;
            depth <= 4'd0;
        end else if (i_exec && (i_dec.instr_type inside {INSTR_GOTO, INSTR_GOSUB})) begin
            pc <= i_dec.target;
            if (push && (depth != 4'(RSTK_DEPTH))) begin
                depth <= depth + 4'd1;          // full stack loses its oldest entry.
            end
        end else if (pop) begin
            pc <= (depth == 4'd0) ? '0 : rstk[0];   // empty stack returns to 0.
            if (depth != 4'd0) begin
                depth <= depth - 4'd1;
            end
        end else if (i_fetch_done) begin
            pc <= pc + 20'd1;
        end
    end

    // ########################################
    // stack storage, shifts on push and pop
    // ########################################

    always_ff @(posedge i_clk) begin
        if (push) begin
            rstk[0] <= pc;                      // pc already points past the GOSUB.
            for (int i = 1; i < RSTK_DEPTH; i++) begin
                rstk[i] <= rstk[i-1];
            end
        end else if (pop) begin
            for (int i = 0; i < RSTK_DEPTH - 1; i++) begin
                rstk[i] <= rstk[i+1];
            end
        end
    end

endmodule

// File: verilog/saturn_inst_decoder.sv
// Instruction decoder.
// Collects fetched nibbles until an instruction is complete, then pulses
// instr_done with the type, immediate and resolved jump target.

`timescale 1ns/10ps

module saturn_inst_decoder import saturn_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_nibble_valid,             // one fetched nibble.
    input  nibble_t i_nibble,
    input  addr_t   i_nibble_pc,                // address of i_nibble.
    input  logic    i_flush,                    // drop a partial instruction.
    saturn_dec_if.dec o_dec
);

    logic      busy;                            // first nibble already taken.
    logic [1:0] remaining;                      // nibbles still to come.
    nibble_t   first;                           // opcode nibble.
    addr_t     base;                            // address of the first offset nibble.
    offset_t   off_sr;                          // offset, filled lowest nibble first.
    offset_t   off_next;
    addr_t     off_ext;
    logic      opens_multi;                     // opcode that needs more nibbles.
    logic      finish;

    // ########################################
    // completion detect
    // ########################################

    assign off_next = {i_nibble, off_sr[11:4]}; // new nibble enters at the top.
    assign off_ext  = {{8{off_next[11]}}, off_next};

    always_comb begin
        opens_multi = (i_nibble == 4'h0) || (i_nibble == 4'h2) ||
                      (i_nibble == 4'h6) || (i_nibble == 4'h7);
        if (busy) begin
            finish = i_nibble_valid && (remaining == 2'd1);
        end else begin
            finish = i_nibble_valid && !opens_multi;   // bad opcode ends at once.
        end
    end

    // ########################################
    // nibble counter
    // ########################################

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            busy             <= 1'b0;
            remaining        <= 2'd0;
            o_dec.instr_done <= 1'b0;
        end else begin
            o_dec.instr_done <= finish;
            if (i_nibble_valid) begin
                if (!busy) begin
                    if (opens_multi) begin
                        busy      <= 1'b1;
                        remaining <= (i_nibble[2]) ? 2'd3 : 2'd1;   // 6 and 7 take three.
                    end
                end else begin
                    remaining <= remaining - 2'd1;
                    if (remaining == 2'd1) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // ########################################
    // operand capture and decode
    // ########################################

    always_ff @(posedge i_clk) begin
        if (i_nibble_valid) begin
            if (!busy) begin
                first <= i_nibble;
                base  <= i_nibble_pc + 20'd1;
            end else begin
                off_sr <= off_next;
            end
        end
        if (finish) begin
            o_dec.imm <= i_nibble;              // last nibble is n for P= n.
            case (busy ? first : i_nibble)
                4'h2: o_dec.instr_type <= INSTR_P_EQ_N;
                4'h6: begin
                    o_dec.instr_type <= INSTR_GOTO;
                    o_dec.target     <= base + off_ext;
                end
                4'h7: begin
                    o_dec.instr_type <= INSTR_GOSUB;
                    o_dec.target     <= base + 20'd3 + off_ext;
                end
                4'h0: o_dec.instr_type <= (i_nibble == 4'h1) ? INSTR_RTN : INSTR_BAD;
                default: o_dec.instr_type <= INSTR_BAD;
            endcase
        end
    end

endmodule

// File: verilog/saturn_ifs.sv
// Internal bundles of the core.
// saturn_fetch_if carries load and fetch requests from the control unit
// to the bus controller; saturn_dec_if carries decoded instructions.

`timescale 1ns/10ps

interface saturn_fetch_if import saturn_pkg::*; ();

    logic    load_req;                          // send load_addr as LOAD_PC.
    addr_t   load_addr;
    logic    fetch_req;                         // read one nibble.
    logic    done;                              // one-cycle pulse at the end.
    nibble_t nibble;                            // read data, valid with done.

    modport ctrl (output load_req, load_addr, fetch_req, input done, nibble);
    modport bus  (input load_req, load_addr, fetch_req, output done, nibble);

endinterface

interface saturn_dec_if import saturn_pkg::*; ();

    logic        instr_done;                    // one-cycle pulse per instruction.
    instr_type_t instr_type;
    nibble_t     imm;                           // value for P= n.
    addr_t       target;                        // jump target, already resolved.

    modport dec  (output instr_done, instr_type, imm, target);
    modport ctrl (input instr_done, instr_type, imm);
    modport pc   (input instr_type, target);

endinterface

// File: verilog/saturn_pkg.sv
// Shared types and constants for the nibble-serial processor front end.
// Every RTL file and the testbench import this package with a wildcard.

package saturn_pkg;

    // ########################################
    // data widths
    // ########################################

    typedef logic [3:0]         nibble_t;       // one 4-bit data nibble.
    typedef logic [19:0]        addr_t;         // nibble address, five nibbles.
    typedef logic signed [11:0] offset_t;       // relative jump offset.

    // ########################################
    // decoder and control encodings
    // ########################################

    typedef enum logic [2:0] {
        INSTR_P_EQ_N,                           // P= n.
        INSTR_GOTO,                             // relative jump.
        INSTR_GOSUB,                            // relative call.
        INSTR_RTN,                              // return from call.
        INSTR_BAD                               // anything not supported.
    } instr_type_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_LOAD,                                // send the pc to the memory.
        ST_FETCH,                               // decide on the next nibble.
        ST_WAIT,                                // read transfer in flight.
        ST_EXEC,
        ST_HALT                                 // stuck here after an error.
    } ctrl_state_t;

    // command nibbles, sent while is_cmd is high.
    localparam nibble_t BUSCMD_LOAD_PC = 4'h2;
    localparam nibble_t BUSCMD_READ    = 4'h0;

    localparam int RSTK_DEPTH   = 8;            // return stack entries.
    localparam int ADDR_NIBBLES = 5;            // nibbles per address on the bus.

endpackage
